//--- miss_pkg.sv
package miss_pkg;

    ////////////////////////////////////////////////////////////
    // address and data widths
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W      = 28;    // l2 request word address
    localparam int LINE_ADDR_W = 26;    // memory line address
    localparam int WORD_SEL_W  = 2;     // 128-bit word within a line
    localparam int LINE_W      = 512;
    localparam int WORD_W      = 128;

    localparam int L2_INDEX_W  = 9;
    localparam int L2_TAG_W    = 18;    // valid bit + 17 address bits
    localparam int L1_INDEX_W  = 8;
    localparam int L1_TAG_W    = 19;    // valid bit + 18 address bits

    ////////////////////////////////////////////////////////////
    // slice positions within the request address
    ////////////////////////////////////////////////////////////

    // line address starts right above the word select
    localparam int LINE_LSB    = WORD_SEL_W;

    // both indexes start at the line address lsb
    // tags sit above their index
    localparam int L2_TAG_LSB  = LINE_LSB + L2_INDEX_W;    // bit 11
    localparam int L1_TAG_LSB  = LINE_LSB + L1_INDEX_W;    // bit 10

    ////////////////////////////////////////////////////////////
    // sequencer states
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        WRITE_MEM = 3'd1,   // dirty victim going out
        READ_MEM  = 3'd2,   // missing line coming in
        FILL_L1   = 3'd3,   // single cycle word forward to l1
        FILL_L2   = 3'd4    // wait for l2 to take the line
    } miss_state_t;

endpackage

//--- miss_req_if.sv
interface miss_req_if #(
    parameter int L2_WAYS = 4
);
    import miss_pkg::*;

    logic [LINE_ADDR_W-1:0]     line_addr;
    logic [WORD_SEL_W-1:0]      word_sel;
    logic [$clog2(L2_WAYS)-1:0] l2_way;     // way being refilled
    logic                       l1_way;     // 2-way l1, one bit
    logic                       to_icache;
    logic                       to_dcache;
    logic                       is_read;

    modport owner (
        output line_addr, word_sel, l2_way, l1_way,
        output to_icache, to_dcache, is_read
    );

    modport user (
        input  line_addr, word_sel, l2_way, l1_way,
        input  to_icache, to_dcache, is_read
    );

endinterface

//--- miss_request_reg.sv
module miss_request_reg #(
    parameter int L2_WAYS = 4
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        accept,
    input  logic [miss_pkg::ADDR_W-1:0] l2_addr,
    input  logic [$clog2(L2_WAYS)-1:0]  l2_choose_way,
    input  logic                        l2_choose_l1,
    input  logic                        ic_en,
    input  logic                        dc_en,
    input  logic                        read_en,
    input  logic                        l2_cache_rw,    // 0 read, 1 write
    miss_req_if.owner                   req
);
    import miss_pkg::*;

    ////////////////////////////////////////////////////////////
    // request flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req.to_icache <= 1'b0;
            req.to_dcache <= 1'b0;
            req.is_read   <= 1'b0;
        end else if (accept) begin
            req.to_icache <= ic_en;
            req.to_dcache <= dc_en | read_en;   // either dcache request kind
            req.is_read   <= ~l2_cache_rw;
        end
    end

    ////////////////////////////////////////////////////////////
    // address and way choices
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            req.line_addr <= l2_addr[ADDR_W-1:LINE_LSB];
            req.word_sel  <= l2_addr[WORD_SEL_W-1:0];
            req.l2_way    <= l2_choose_way;
            req.l1_way    <= l2_choose_l1;
        end
    end

endmodule

//--- victim_select.sv
module victim_select #(
    parameter int L2_WAYS = 4
) (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       accept_dirty,
    input  logic [miss_pkg::ADDR_W-1:0]                l2_addr,
    input  logic [$clog2(L2_WAYS)-1:0]                 l2_choose_way,
    input  logic [L2_WAYS-1:0][miss_pkg::L2_TAG_W-1:0] l2_tag_rd,
    input  logic [L2_WAYS-1:0][miss_pkg::LINE_W-1:0]   l2_data_rd,
    output logic [miss_pkg::LINE_ADDR_W-1:0]           wb_addr,
    output logic [miss_pkg::LINE_W-1:0]                wb_data
);
    import miss_pkg::*;

    logic [L2_TAG_W-1:0]    victim_tag;
    logic [L2_INDEX_W-1:0]  victim_index;
    logic [LINE_ADDR_W-1:0] victim_addr;

    // tag of the way about to be evicted
    assign victim_tag   = l2_tag_rd[l2_choose_way];
    assign victim_index = l2_addr[LINE_LSB +: L2_INDEX_W];

    // drop the valid bit, the rest is the old line's upper address
    assign victim_addr  = {victim_tag[L2_TAG_W-2:0], victim_index};

    ////////////////////////////////////////////////////////////
    // write-back holding registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_addr <= '0;
        end else if (accept_dirty) begin
            wb_addr <= victim_addr;
        end
    end

    // line stays put until the next dirty miss
    always_ff @(posedge clk) begin
        if (accept_dirty) begin
            wb_data <= l2_data_rd[l2_choose_way];
        end
    end

endmodule

//--- refill_router.sv
module refill_router #(
    parameter int L2_WAYS = 4
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             line_capture,
    input  logic                             l1_fill,
    input  logic                             l2_fill,
    input  logic [miss_pkg::LINE_W-1:0]      mem_rd,
    miss_req_if.user                         req,

    // l2 refill
    output logic [L2_WAYS-1:0]               l2_block_we,
    output logic [miss_pkg::L2_INDEX_W-1:0]  l2_index_mem,
    output logic [miss_pkg::L2_TAG_W-1:0]    l2_tag_wd_mem,
    output logic                             wd_from_mem_en,
    output logic [miss_pkg::LINE_W-1:0]      refill_line,

    // l1 fill
    output logic [miss_pkg::WORD_W-1:0]      data_wd_l2_mem,
    output logic                             data_wd_l2_en_mem,
    output logic                             mem_wr_ic_en,
    output logic                             mem_wr_dc_en,
    output logic [1:0]                       ic_block_we,
    output logic [1:0]                       dc_block_we,
    output logic [miss_pkg::L1_INDEX_W-1:0]  l1_index_mem,
    output logic [miss_pkg::L1_TAG_W-1:0]    l1_tag_wd_mem
);
    import miss_pkg::*;

    logic [LINE_W-1:0] line_q;
    logic              l1_go;
    logic [1:0]        l1_way_oh;

    ////////////////////////////////////////////////////////////
    // line from memory
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_q <= '0;
        end else if (line_capture) begin
            line_q <= mem_rd;   // taken on the mem_complete_r cycle
        end
    end

    assign refill_line = line_q;

    ////////////////////////////////////////////////////////////
    // l2 side
    ////////////////////////////////////////////////////////////

    // one-hot of the chosen way, only while the fill runs
    assign l2_block_we    = l2_fill ? (L2_WAYS'(1) << req.l2_way) : '0;
    assign wd_from_mem_en = l2_fill;

    // index is the low end of the line address
    assign l2_index_mem   = req.line_addr[L2_INDEX_W-1:0];
    assign l2_tag_wd_mem  = {1'b1, req.line_addr[L2_TAG_LSB-LINE_LSB +: L2_TAG_W-1]};

    ////////////////////////////////////////////////////////////
    // l1 side
    ////////////////////////////////////////////////////////////

    // write misses skip the l1 forward
    assign l1_go = l1_fill & req.is_read;

    assign l1_way_oh = {req.l1_way, ~req.l1_way};

    assign data_wd_l2_mem    = line_q[req.word_sel*WORD_W +: WORD_W];
    assign data_wd_l2_en_mem = l1_go;

    assign mem_wr_ic_en = l1_go & req.to_icache;
    assign mem_wr_dc_en = l1_go & req.to_dcache;

    assign ic_block_we  = mem_wr_ic_en ? l1_way_oh : 2'b00;
    assign dc_block_we  = mem_wr_dc_en ? l1_way_oh : 2'b00;

    // same index and tag go to whichever l1 is filled
    assign l1_index_mem  = req.line_addr[L1_INDEX_W-1:0];
    assign l1_tag_wd_mem = {1'b1, req.line_addr[L1_TAG_LSB-LINE_LSB +: L1_TAG_W-1]};

endmodule

//--- miss_sequencer.sv
module miss_sequencer (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             access_mem_clean,
    input  logic                             access_mem_dirty,
    input  logic                             mem_complete_w,
    input  logic                             mem_complete_r,
    input  logic                             l2_complete_w,
    miss_req_if.user                         req,
    input  logic [miss_pkg::LINE_ADDR_W-1:0] wb_addr,

    // strobes to the datapath blocks
    output logic                             accept,
    output logic                             accept_dirty,
    output logic                             line_capture,
    output logic                             l1_fill,
    output logic                             l2_fill,

    // memory side and status
    output logic                             mem_re,
    output logic                             mem_we,
    output logic [miss_pkg::LINE_ADDR_W-1:0] mem_addr,
    output logic                             memory_busy,
    output logic                             refill_done
);
    import miss_pkg::*;

    miss_state_t state;
    miss_state_t state_nxt;

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // clean wins when both are raised
                if (access_mem_clean) begin
                    state_nxt = READ_MEM;
                end else if (access_mem_dirty) begin
                    state_nxt = WRITE_MEM;
                end
            end
            WRITE_MEM: begin
                if (mem_complete_w) begin
                    state_nxt = READ_MEM;
                end
            end
            READ_MEM: begin
                if (mem_complete_r) begin
                    state_nxt = FILL_L1;
                end
            end
            FILL_L1: begin
                state_nxt = FILL_L2;    // always one cycle
            end
            FILL_L2: begin
                if (l2_complete_w) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////////////////////////
    // strobes
    ////////////////////////////////////////////////////////////

    assign accept       = (state == IDLE) & (access_mem_clean | access_mem_dirty);
    assign accept_dirty = (state == IDLE) & ~access_mem_clean & access_mem_dirty;
    assign line_capture = (state == READ_MEM) & mem_complete_r;
    assign l1_fill      = (state == FILL_L1);
    assign l2_fill      = (state == FILL_L1) | (state == FILL_L2);   // held until l2 acks

    ////////////////////////////////////////////////////////////
    // memory interface
    ////////////////////////////////////////////////////////////

    // level requests, held while memory is slow
    assign mem_we = (state == WRITE_MEM);
    assign mem_re = (state == READ_MEM);

    // victim address only during the write-back
    assign mem_addr = (state == WRITE_MEM) ? wb_addr : req.line_addr;

    assign memory_busy = (state != IDLE);
    assign refill_done = (state == FILL_L2) & l2_complete_w;

endmodule

//--- memory_ctrl.sv
module memory_ctrl #(
    parameter int L2_WAYS = 4
) (
    input  logic                                       clk,
    input  logic                                       arst_n,

    // miss requests from l2
    input  logic                                       access_mem_clean,
    input  logic                                       access_mem_dirty,
    input  logic [miss_pkg::ADDR_W-1:0]                l2_addr,
    input  logic [$clog2(L2_WAYS)-1:0]                 l2_choose_way,
    input  logic                                       l2_choose_l1,
    input  logic                                       l2_cache_rw,
    input  logic                                       ic_en,
    input  logic                                       dc_en,
    input  logic                                       read_en,

    // l2 arrays
    input  logic [L2_WAYS-1:0][miss_pkg::L2_TAG_W-1:0] l2_tag_rd,
    input  logic [L2_WAYS-1:0][miss_pkg::LINE_W-1:0]   l2_data_rd,
    input  logic                                       l2_complete_w,
    output logic [L2_WAYS-1:0]                         l2_block_we,
    output logic [miss_pkg::L2_INDEX_W-1:0]            l2_index_mem,
    output logic [miss_pkg::L2_TAG_W-1:0]              l2_tag_wd_mem,
    output logic                                       wd_from_mem_en,
    output logic [miss_pkg::LINE_W-1:0]                l2_line_wd,

    // l1 fill
    output logic [miss_pkg::WORD_W-1:0]                data_wd_l2_mem,
    output logic                                       data_wd_l2_en_mem,
    output logic                                       mem_wr_ic_en,
    output logic                                       mem_wr_dc_en,
    output logic [1:0]                                 ic_block_we,
    output logic [1:0]                                 dc_block_we,
    output logic [miss_pkg::L1_INDEX_W-1:0]            l1_index_mem,
    output logic [miss_pkg::L1_TAG_W-1:0]              l1_tag_wd_mem,

    // main memory
    input  logic                                       mem_complete_w,
    input  logic                                       mem_complete_r,
    input  logic [miss_pkg::LINE_W-1:0]                mem_rd,
    output logic [miss_pkg::LINE_W-1:0]                mem_wd,
    output logic [miss_pkg::LINE_ADDR_W-1:0]           mem_addr,
    output logic                                       mem_we,
    output logic                                       mem_re,

    output logic                                       memory_busy,
    output logic                                       refill_done
);

    logic                             accept;
    logic                             accept_dirty;
    logic                             line_capture;
    logic                             l1_fill;
    logic                             l2_fill;
    logic [miss_pkg::LINE_ADDR_W-1:0] wb_addr;

    miss_req_if #(.L2_WAYS(L2_WAYS)) u_req_if ();

    miss_request_reg #(.L2_WAYS(L2_WAYS)) u_request_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .accept        (accept),
        .l2_addr       (l2_addr),
        .l2_choose_way (l2_choose_way),
        .l2_choose_l1  (l2_choose_l1),
        .ic_en         (ic_en),
        .dc_en         (dc_en),
        .read_en       (read_en),
        .l2_cache_rw   (l2_cache_rw),
        .req           (u_req_if.owner)
    );

    // victim line drives the memory write data directly
    victim_select #(.L2_WAYS(L2_WAYS)) u_victim_select (
        .clk           (clk),
        .arst_n        (arst_n),
        .accept_dirty  (accept_dirty),
        .l2_addr       (l2_addr),
        .l2_choose_way (l2_choose_way),
        .l2_tag_rd     (l2_tag_rd),
        .l2_data_rd    (l2_data_rd),
        .wb_addr       (wb_addr),
        .wb_data       (mem_wd)
    );

    refill_router #(.L2_WAYS(L2_WAYS)) u_refill_router (
        .clk               (clk),
        .arst_n            (arst_n),
        .line_capture      (line_capture),
        .l1_fill           (l1_fill),
        .l2_fill           (l2_fill),
        .mem_rd            (mem_rd),
        .req               (u_req_if.user),
        .l2_block_we       (l2_block_we),
        .l2_index_mem      (l2_index_mem),
        .l2_tag_wd_mem     (l2_tag_wd_mem),
        .wd_from_mem_en    (wd_from_mem_en),
        .refill_line       (l2_line_wd),
        .data_wd_l2_mem    (data_wd_l2_mem),
        .data_wd_l2_en_mem (data_wd_l2_en_mem),
        .mem_wr_ic_en      (mem_wr_ic_en),
        .mem_wr_dc_en      (mem_wr_dc_en),
        .ic_block_we       (ic_block_we),
        .dc_block_we       (dc_block_we),
        .l1_index_mem      (l1_index_mem),
        .l1_tag_wd_mem     (l1_tag_wd_mem)
    );

    miss_sequencer u_sequencer (
        .clk              (clk),
        .arst_n           (arst_n),
        .access_mem_clean (access_mem_clean),
        .access_mem_dirty (access_mem_dirty),
        .mem_complete_w   (mem_complete_w),
        .mem_complete_r   (mem_complete_r),
        .l2_complete_w    (l2_complete_w),
        .req              (u_req_if.user),
        .wb_addr          (wb_addr),
        .accept           (accept),
        .accept_dirty     (accept_dirty),
        .line_capture     (line_capture),
        .l1_fill          (l1_fill),
        .l2_fill          (l2_fill),
        .mem_re           (mem_re),
        .mem_we           (mem_we),
        .mem_addr         (mem_addr),
        .memory_busy      (memory_busy),
        .refill_done      (refill_done)
    );

endmodule

//--- tb_memory_ctrl.sv
module tb_memory_ctrl;
    timeunit 1ns;
    timeprecision 1ps;
    import miss_pkg::*;

    localparam int L2_WAYS        = 4;
    localparam int N_ENTRIES      = 8;
    localparam int RESET_CYCLES   = 10;
    localparam int MAX_LAT        = 6;    // table base up to 4 plus random extra up to 2
    // worst latency for write-back, read and l2 fill plus per-entry overhead
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ENTRIES * (3 * MAX_LAT + 10);

    typedef struct packed {
        logic [1:0]  kind;      // 0 clean, 1 dirty, 2 both raised
        logic [27:0] addr;
        logic [1:0]  way;
        logic        l1_way;
        logic        to_ic;
        logic        is_write;
        logic [16:0] vtag;
        logic [3:0]  mem_lat;
        logic [3:0]  l2_lat;
    } miss_entry_t;

    logic                              clk;
    logic                              arst_n;
    logic                              access_mem_clean;
    logic                              access_mem_dirty;
    logic [ADDR_W-1:0]                 l2_addr;
    logic [1:0]                        l2_choose_way;
    logic                              l2_choose_l1;
    logic                              l2_cache_rw;
    logic                              ic_en;
    logic                              dc_en;
    logic                              read_en;
    logic [L2_WAYS-1:0][L2_TAG_W-1:0]  l2_tag_rd;
    logic [L2_WAYS-1:0][LINE_W-1:0]    l2_data_rd;
    logic                              l2_complete_w;
    logic [L2_WAYS-1:0]                l2_block_we;
    logic [L2_INDEX_W-1:0]             l2_index_mem;
    logic [L2_TAG_W-1:0]               l2_tag_wd_mem;
    logic                              wd_from_mem_en;
    logic [LINE_W-1:0]                 l2_line_wd;
    logic [WORD_W-1:0]                 data_wd_l2_mem;
    logic                              data_wd_l2_en_mem;
    logic                              mem_wr_ic_en;
    logic                              mem_wr_dc_en;
    logic [1:0]                        ic_block_we;
    logic [1:0]                        dc_block_we;
    logic [L1_INDEX_W-1:0]             l1_index_mem;
    logic [L1_TAG_W-1:0]               l1_tag_wd_mem;
    logic                              mem_complete_w;
    logic                              mem_complete_r;
    logic [LINE_W-1:0]                 mem_rd;
    logic [LINE_W-1:0]                 mem_wd;
    logic [LINE_ADDR_W-1:0]            mem_addr;
    logic                              mem_we;
    logic                              mem_re;
    logic                              memory_busy;
    logic                              refill_done;

    miss_entry_t table_q [N_ENTRIES];
    miss_state_t seq_state;
    int          seed = 32'h1218_e143;
    int          error_count = 0;
    int          check_count = 0;
    int          done_count = 0;
    int          cycle_count = 0;

    // per-entry memory and l2 model state
    int   wcnt, rcnt, l2cnt, lat_w, lat_r, lat_l2;
    int   we_rise, re_rise, l1_fills;
    logic we_prev, re_prev, done;
    logic cw_next, cr_next, l2c_next;

    memory_ctrl #(.L2_WAYS(L2_WAYS)) u_memory_ctrl (.*);

    assign seq_state = u_memory_ctrl.u_sequencer.state;   // for messages

    // every refill_done pulse over the whole run
    always @(negedge clk) begin
        if (refill_done) begin
            done_count++;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference patterns
    ////////////////////////////////////////////////////////////

    function automatic logic [WORD_W-1:0] mem_word(input logic [25:0] la, input logic [1:0] w);
        return {16'hc0de, 14'h0, w, 6'h0, la, 6'h3f, ~la, 6'h0, la ^ {24'h0, w}};
    endfunction

    function automatic logic [LINE_W-1:0] mem_line(input logic [25:0] la);
        logic [LINE_W-1:0] line;
        for (int k = 0; k < 4; k++) begin
            line[k*WORD_W +: WORD_W] = mem_word(la, 2'(k));
        end
        return line;
    endfunction

    // victim contents depend on way and tag
    function automatic logic [LINE_W-1:0] victim_line(input logic [1:0] way,
                                                      input logic [16:0] tag);
        logic [LINE_W-1:0] line;
        for (int k = 0; k < 16; k++) begin
            line[k*32 +: 32] = {6'h15, way, 4'(k), 3'h0, tag};
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s got %0h expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("failure at %0t in state %s, %s", $time, seq_state.name(), what);
    endtask

    task automatic check_idle_outputs();
        check_value("mem_re", 512'(mem_re), 512'(0));
        check_value("mem_we", 512'(mem_we), 512'(0));
        check_value("memory_busy", 512'(memory_busy), 512'(0));
        check_value("wd_from_mem_en", 512'(wd_from_mem_en), 512'(0));
        check_value("l2_block_we", 512'(l2_block_we), 512'(0));
        check_value("data_wd_l2_en_mem", 512'(data_wd_l2_en_mem), 512'(0));
        check_value("mem_wr_ic_en", 512'(mem_wr_ic_en), 512'(0));
        check_value("mem_wr_dc_en", 512'(mem_wr_dc_en), 512'(0));
        check_value("ic_block_we", 512'(ic_block_we), 512'(0));
        check_value("dc_block_we", 512'(dc_block_we), 512'(0));
        check_value("refill_done", 512'(refill_done), 512'(0));
    endtask

    ////////////////////////////////////////////////////////////
    // per-cycle checks and models
    ////////////////////////////////////////////////////////////

    task automatic sample_cycle(input miss_entry_t e);
        logic [25:0] la;
        logic [1:0]  l1_oh;
        la    = e.addr[27:2];
        l1_oh = e.l1_way ? 2'b10 : 2'b01;
        check_value("memory_busy", 512'(memory_busy), 512'(1));
        if (mem_we && mem_re) report_failure("mem_we and mem_re are high together");
        if (mem_we) begin
            if (e.kind != 2'd1) report_failure("write-back started on a clean miss");
            if (re_rise != 0) report_failure("write-back came after the line read");
            check_value("mem_addr", 512'(mem_addr), 512'({e.vtag, e.addr[10:2]}));
            check_value("mem_wd", mem_wd, victim_line(e.way, e.vtag));
        end
        if (mem_re) begin
            if (e.kind == 2'd1 && we_rise == 0) report_failure("line read before write-back");
            check_value("mem_addr", 512'(mem_addr), 512'(la));
        end
        if (mem_we && !we_prev) we_rise++;
        if (mem_re && !re_prev) re_rise++;

        if (wd_from_mem_en) begin
            check_value("l2_block_we", 512'(l2_block_we), 512'(4'b0001 << e.way));
            check_value("l2_index_mem", 512'(l2_index_mem), 512'(e.addr[10:2]));
            check_value("l2_tag_wd_mem", 512'(l2_tag_wd_mem), 512'({1'b1, e.addr[27:11]}));
            check_value("l2_line_wd", l2_line_wd, mem_line(la));
            if (!l2_complete_w) l2cnt++;
        end else begin
            check_value("l2_block_we", 512'(l2_block_we), 512'(0));
        end

        if (data_wd_l2_en_mem) begin
            l1_fills++;
            if (e.is_write) report_failure("l1 fill raised on a write miss");
            check_value("data_wd_l2_mem", 512'(data_wd_l2_mem), 512'(mem_word(la, e.addr[1:0])));
            check_value("mem_wr_ic_en", 512'(mem_wr_ic_en), 512'(e.to_ic));
            check_value("mem_wr_dc_en", 512'(mem_wr_dc_en), 512'(!e.to_ic));
            check_value("ic_block_we", 512'(ic_block_we), 512'(e.to_ic ? l1_oh : 2'b00));
            check_value("dc_block_we", 512'(dc_block_we), 512'(e.to_ic ? 2'b00 : l1_oh));
            check_value("l1_index_mem", 512'(l1_index_mem), 512'(e.addr[9:2]));
            check_value("l1_tag_wd_mem", 512'(l1_tag_wd_mem), 512'({1'b1, e.addr[27:10]}));
        end else begin
            check_value("l1 strobes", 512'({mem_wr_ic_en, mem_wr_dc_en, ic_block_we, dc_block_we}),
                        512'(0));
        end

        // memory and l2 answer after their latency
        if (mem_we && !mem_complete_w) wcnt++;
        if (mem_re && !mem_complete_r) rcnt++;
        cw_next  = mem_we && !mem_complete_w && (wcnt >= lat_w);
        cr_next  = mem_re && !mem_complete_r && (rcnt >= lat_r);
        l2c_next = wd_from_mem_en && !l2_complete_w && (l2cnt >= lat_l2);
        if (refill_done) begin
            done = 1'b1;
        end
        we_prev = mem_we;
        re_prev = mem_re;
    endtask

    task automatic drive_models(input int n, input miss_entry_t e);
        mem_complete_w = cw_next;
        mem_complete_r = cr_next;
        mem_rd         = cr_next ? mem_line(mem_addr) : {16{32'hdead_beef}};
        l2_complete_w  = l2c_next;
        if (n == 0) begin   // stray miss while busy must be ignored
            access_mem_clean = 1'b1;
            access_mem_dirty = 1'b1;
            l2_addr          = ~e.addr;
        end else if (n == 1) begin
            access_mem_clean = 1'b0;
            access_mem_dirty = 1'b0;
        end
    endtask

    // entered 1 ns after a rising edge and left at a falling edge
    task automatic run_entry(input int i);
        miss_entry_t     e;
        int              n;
        logic [16:0]     vt;
        e      = table_q[i];
        lat_w  = int'(e.mem_lat) + ({$random(seed)} % 3);
        lat_r  = int'(e.mem_lat) + ({$random(seed)} % 3);
        lat_l2 = int'(e.l2_lat) + ({$random(seed)} % 3);
        wcnt     = 0;
        rcnt     = 0;
        l2cnt    = 0;
        we_rise  = 0;
        re_rise  = 0;
        l1_fills = 0;
        we_prev  = 1'b0;
        re_prev  = 1'b0;
        done     = 1'b0;
        l2_addr       = e.addr;
        l2_choose_way = e.way;
        l2_choose_l1  = e.l1_way;
        l2_cache_rw   = e.is_write;
        ic_en         = e.to_ic;
        dc_en         = !e.to_ic && !i[0];
        read_en       = !e.to_ic && i[0];
        for (int w = 0; w < L2_WAYS; w++) begin
            vt = (w == int'(e.way)) ? e.vtag : ~e.vtag ^ 17'(w);
            l2_tag_rd[w]  = {1'b1, vt};
            l2_data_rd[w] = victim_line(2'(w), vt);
        end
        access_mem_clean = (e.kind != 2'd1);
        access_mem_dirty = (e.kind != 2'd0);
        @(negedge clk);
        check_value("memory_busy", 512'(memory_busy), 512'(0));
        @(posedge clk);
        #1;
        access_mem_clean = 1'b0;
        access_mem_dirty = 1'b0;
        n = 0;
        while (!done) begin
            @(negedge clk);
            sample_cycle(e);
            @(posedge clk);
            #1;
            drive_models(n, e);
            n++;
        end
        @(negedge clk);
        check_idle_outputs();
        check_value("write-back count", 512'(we_rise), 512'(e.kind == 2'd1));
        check_value("line read count", 512'(re_rise), 512'(1));
        check_value("l1 fill count", 512'(l1_fills), 512'(!e.is_write));
    endtask

    ////////////////////////////////////////////////////////////
    // clock, timeout and main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles in state %s", cycle_count, seq_state.name());
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        table_q[0] = '{2'd0, 28'h123_4567, 2'd1, 1'b0, 1'b1, 1'b0, 17'h0_0abc, 4'd1, 4'd1};
        table_q[1] = '{2'd1, 28'h89a_bcde, 2'd2, 1'b1, 1'b0, 1'b0, 17'h1_5a5a, 4'd3, 4'd2};
        table_q[2] = '{2'd0, 28'hfed_cba9, 2'd3, 1'b1, 1'b0, 1'b1, 17'h0_1234, 4'd2, 4'd4};
        table_q[3] = '{2'd2, 28'h055_aa33, 2'd0, 1'b0, 1'b0, 1'b0, 17'h1_ffff, 4'd4, 4'd1};
        table_q[4] = '{2'd1, 28'h3c3_c3c2, 2'd0, 1'b0, 1'b1, 1'b0, 17'h0_0001, 4'd1, 4'd3};
        table_q[5] = '{2'd1, 28'habc_0011, 2'd3, 1'b1, 1'b1, 1'b1, 17'h1_0000, 4'd2, 4'd2};
        table_q[6] = '{2'd0, 28'h000_0000, 2'd2, 1'b1, 1'b1, 1'b0, 17'h0_7777, 4'd4, 4'd4};
        table_q[7] = '{2'd1, 28'hfff_ffff, 2'd1, 1'b0, 1'b0, 1'b0, 17'h0_aaaa, 4'd3, 4'd1};

        arst_n = 1'b0;
        access_mem_clean = 1'b0;
        access_mem_dirty = 1'b0;
        l2_addr = '0;
        l2_choose_way = '0;
        l2_choose_l1 = 1'b0;
        l2_cache_rw = 1'b0;
        ic_en = 1'b0;
        dc_en = 1'b0;
        read_en = 1'b0;
        l2_tag_rd = '0;
        l2_data_rd = '0;
        l2_complete_w = 1'b0;
        mem_complete_w = 1'b0;
        mem_complete_r = 1'b0;
        mem_rd = '0;
        cw_next = 1'b0;
        cr_next = 1'b0;
        l2c_next = 1'b0;

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();   // still in reset
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();

        for (int i = 0; i < N_ENTRIES; i++) begin
            @(posedge clk);
            #1;
            run_entry(i);
        end
        check_value("refill_done total", 512'(done_count), 512'(N_ENTRIES));

        $display("checks run %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
miss_pkg.sv
miss_req_if.sv
miss_request_reg.sv
victim_select.sv
refill_router.sv
miss_sequencer.sv
memory_ctrl.sv
tb_memory_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the memory_ctrl testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --timescale 1ns/1ps \
    --top-module tb_memory_ctrl -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_memory_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
